// ==== Makefile ====
RTL = src/backend_pkg.sv src/int_reg_file.sv src/issue_stage.sv src/alu.sv \
      src/iter_multiplier.sv src/iter_divider.sv src/exec_pipeline.sv src/int_backend.sv

.PHONY: lint sim clean

lint:
	verilator --lint-only --top-module int_backend $(RTL)

sim:
	verilator --binary --timing --assert -f compile.f --top-module tb_int_backend \
		-o tb_int_backend
	./obj_dir/tb_int_backend | tee /dev/stderr | grep -qF '** PASS **'

clean:
	rm -rf obj_dir

// ==== compile.f ====
src/backend_pkg.sv
src/int_reg_file.sv
src/issue_stage.sv
src/alu.sv
src/iter_multiplier.sv
src/iter_divider.sv
src/exec_pipeline.sv
src/int_backend.sv
testbench/tb_int_backend.sv

// ==== src/alu.sv ====
`timescale 1ns/100ps

module alu import backend_pkg::*; (
  input  opcode_e          opcode_i,
  input  logic [XLEN-1:0]  op_a_i,
  input  logic [XLEN-1:0]  op_b_i,
  input  logic [IMM_W-1:0] imm_i,
  output logic [XLEN-1:0]  result_o
);

  logic [XLEN-1:0]         imm_ext;
  logic [$clog2(XLEN)-1:0] shamt;

  assign imm_ext = {{(XLEN-IMM_W){imm_i[IMM_W-1]}}, imm_i};
  assign shamt   = op_b_i[$clog2(XLEN)-1:0];

  always_comb begin
    unique case (opcode_i)
      OPC_ADD:  result_o = op_a_i + op_b_i;
      OPC_SUB:  result_o = op_a_i - op_b_i;
      OPC_AND:  result_o = op_a_i & op_b_i;
      OPC_OR:   result_o = op_a_i | op_b_i;
      OPC_XOR:  result_o = op_a_i ^ op_b_i;
      OPC_SLL:  result_o = op_a_i << shamt;
      OPC_SRL:  result_o = op_a_i >> shamt;
      OPC_ADDI: result_o = op_a_i + imm_ext;
      // Multi-cycle opcodes take their result from their own unit
      default:  result_o = '0;
    endcase
  end

endmodule

// ==== src/backend_pkg.sv ====
package backend_pkg;

  // Datapath and register file geometry
  localparam int XLEN         = 32;
  localparam int REG_ADDR_W   = 5;
  localparam int NUM_REGS     = 32;
  localparam int IMM_W        = 16;

  // Iterative units take one bit per cycle
  localparam int MULDIV_STEPS = XLEN;
  localparam int MULDIV_CNT_W = $clog2(MULDIV_STEPS + 1);

  typedef enum logic [3:0] {
    OPC_ADD,
    OPC_SUB,
    OPC_AND,
    OPC_OR,
    OPC_XOR,
    OPC_SLL,
    OPC_SRL,
    OPC_ADDI,
    OPC_MUL,
    OPC_DIVU,
    OPC_REMU
  } opcode_e;

  // Unit that owns the result of an EX slot
  typedef enum logic [1:0] {
    FU_ALU,
    FU_MUL,
    FU_DIV
  } func_unit_e;

  // Shared by the multiplier and the divider
  typedef enum logic [1:0] {
    MD_IDLE,
    MD_BUSY,
    MD_DONE
  } muldiv_state_e;

  typedef struct packed {
    opcode_e               opcode;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [IMM_W-1:0]      imm;
  } instr_t;

  // Operands are already bypassed
  typedef struct packed {
    logic                  valid;
    opcode_e               opcode;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       op_a;
    logic [XLEN-1:0]       op_b;
    logic [IMM_W-1:0]      imm;
  } issue_t;

  typedef struct packed {
    logic                  pending;
    logic [REG_ADDR_W-1:0] rd;
    logic                  data_valid;
    logic [XLEN-1:0]       data;
  } fwd_t;

  typedef struct packed {
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       data;
  } commit_t;

endpackage

// ==== src/exec_pipeline.sv ====
`timescale 1ns/100ps

module exec_pipeline import backend_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_ni,
  input  issue_t  candidate_i,
  input  issue_t  issue_i,
  output logic    can_accept_o,
  output fwd_t    ex1_fwd_o,
  output fwd_t    ex2_fwd_o,
  output logic    commit_valid_o,
  output commit_t commit_o
);

  logic                  ex1_pending_q, ex1_pending_d;
  func_unit_e            ex1_select_q, ex1_select_d;
  logic [REG_ADDR_W-1:0] ex1_rd_q, ex1_rd_d;
  logic [XLEN-1:0]       ex1_alu_data_q, ex1_alu_data_d;
  logic                  ex2_pending_q, ex2_pending_d;
  func_unit_e            ex2_select_q, ex2_select_d;
  logic [REG_ADDR_W-1:0] ex2_rd_q, ex2_rd_d;
  logic [XLEN-1:0]       ex2_alu_data_q, ex2_alu_data_d;
  logic                  ex1_data_valid, ex2_data_valid;
  logic [XLEN-1:0]       ex1_data, ex2_data;
  logic                  ex1_ready, ex2_ready;
  logic                  mul_ready, mul_valid, div_ready, div_valid;
  logic [XLEN-1:0]       mul_data, div_data, alu_result;
  func_unit_e            issue_unit;

  function automatic func_unit_e unit_of(input opcode_e op);
    case (op)
      OPC_MUL:            return FU_MUL;
      OPC_DIVU, OPC_REMU: return FU_DIV;
      default:            return FU_ALU;
    endcase
  endfunction

  assign issue_unit = unit_of(issue_i.opcode);

  alu u_alu (
    .opcode_i (issue_i.opcode), .op_a_i (issue_i.op_a), .op_b_i (issue_i.op_b),
    .imm_i    (issue_i.imm),    .result_o (alu_result)
  );

  iter_multiplier u_mul (
    .clk_i, .rst_ni,
    .req_valid_i  (issue_i.valid && issue_unit == FU_MUL), .req_ready_o (mul_ready),
    .op_a_i       (issue_i.op_a), .op_b_i (issue_i.op_b),
    .resp_valid_o (mul_valid),    .resp_value_o (mul_data)
  );

  iter_divider u_div (
    .clk_i, .rst_ni,
    .req_valid_i  (issue_i.valid && issue_unit == FU_DIV), .req_ready_o (div_ready),
    .rem_i        (issue_i.opcode == OPC_REMU),
    .op_a_i       (issue_i.op_a), .op_b_i (issue_i.op_b),
    .resp_valid_o (div_valid),    .resp_value_o (div_data)
  );

  ////////////////////
  // Structure hazard
  ////////////////////

  assign ex2_ready = !ex2_pending_q || ex2_data_valid;
  assign ex1_ready = !ex1_pending_q || ex2_ready;

  always_comb begin
    can_accept_o = ex1_ready;
    unique case (unit_of(candidate_i.opcode))
      FU_MUL:  can_accept_o = ex1_ready && mul_ready;
      FU_DIV:  can_accept_o = ex1_ready && div_ready;
      default: can_accept_o = ex1_ready;
    endcase
  end

  ////////////////////
  // EX1 stage
  ////////////////////

  // A unit response belongs to EX2 while EX2 still waits on that unit
  always_comb begin
    unique case (ex1_select_q)
      FU_MUL: begin
        ex1_data_valid = mul_valid && ex2_select_q != FU_MUL;
        ex1_data       = mul_data;
      end
      FU_DIV: begin
        ex1_data_valid = div_valid && ex2_select_q != FU_DIV;
        ex1_data       = div_data;
      end
      default: begin
        ex1_data_valid = 1'b1;
        ex1_data       = ex1_alu_data_q;
      end
    endcase
  end

  always_comb begin
    ex1_pending_d  = ex1_pending_q;
    ex1_select_d   = ex1_select_q;
    ex1_rd_d       = ex1_rd_q;
    ex1_alu_data_d = ex1_alu_data_q;
    // Fold a finished result so it survives the unit taking a new request
    if (ex1_data_valid) begin
      ex1_select_d   = FU_ALU;
      ex1_alu_data_d = ex1_data;
    end
    if (ex2_ready) begin
      ex1_pending_d = 1'b0;
      ex1_select_d  = FU_ALU;
    end
    if (issue_i.valid) begin
      ex1_pending_d  = 1'b1;
      ex1_select_d   = issue_unit;
      ex1_rd_d       = issue_i.rd;
      ex1_alu_data_d = alu_result;
    end
  end

  ////////////////////
  // EX2 stage
  ////////////////////

  always_comb begin
    unique case (ex2_select_q)
      FU_MUL:  {ex2_data_valid, ex2_data} = {mul_valid, mul_data};
      FU_DIV:  {ex2_data_valid, ex2_data} = {div_valid, div_data};
      default: {ex2_data_valid, ex2_data} = {1'b1, ex2_alu_data_q};
    endcase
  end

  always_comb begin
    ex2_pending_d  = ex2_pending_q;
    ex2_select_d   = ex2_select_q;
    ex2_rd_d       = ex2_rd_q;
    ex2_alu_data_d = ex2_alu_data_q;
    if (ex2_data_valid) begin
      ex2_pending_d = 1'b0;
      ex2_select_d  = FU_ALU;
    end
    if (ex1_pending_q && ex2_ready) begin
      ex2_pending_d = 1'b1;
      ex2_select_d  = ex1_data_valid ? FU_ALU : ex1_select_q;
      ex2_rd_d      = ex1_rd_q;
      if (ex1_data_valid) begin
        ex2_alu_data_d = ex1_data;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ex1_pending_q <= 1'b0;
      ex1_select_q  <= FU_ALU;
      ex2_pending_q <= 1'b0;
      ex2_select_q  <= FU_ALU;
    end else begin
      ex1_pending_q <= ex1_pending_d;
      ex1_select_q  <= ex1_select_d;
      ex2_pending_q <= ex2_pending_d;
      ex2_select_q  <= ex2_select_d;
    end
  end

  always_ff @(posedge clk_i) begin
    ex1_rd_q       <= ex1_rd_d;
    ex1_alu_data_q <= ex1_alu_data_d;
    ex2_rd_q       <= ex2_rd_d;
    ex2_alu_data_q <= ex2_alu_data_d;
  end

  assign ex1_fwd_o      = '{pending: ex1_pending_q, rd: ex1_rd_q,
                            data_valid: ex1_data_valid, data: ex1_data};
  assign ex2_fwd_o      = '{pending: ex2_pending_q, rd: ex2_rd_q,
                            data_valid: ex2_data_valid, data: ex2_data};
  assign commit_valid_o = ex2_pending_q && ex2_data_valid;
  assign commit_o       = '{rd: ex2_rd_q, data: ex2_data};

  assert property (@(posedge clk_i) disable iff (!rst_ni) commit_valid_o |-> ex2_pending_q)
    else $error("ERR commit_valid_o with empty EX2, rd %h", ex2_rd_q);

endmodule

// ==== src/int_backend.sv ====
`timescale 1ns/100ps

module int_backend import backend_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_ni,
  input  logic    instr_valid_i,
  output logic    instr_ready_o,
  input  instr_t  instr_i,
  output logic    commit_valid_o,
  output commit_t commit_o
);

  logic [REG_ADDR_W-1:0] rs1_addr;
  logic [REG_ADDR_W-1:0] rs2_addr;
  logic [XLEN-1:0]       rs1_data;
  logic [XLEN-1:0]       rs2_data;
  fwd_t                  ex1_fwd;
  fwd_t                  ex2_fwd;
  logic                  can_accept;
  issue_t                candidate;
  issue_t                issue_req;

  issue_stage u_issue (
    .clk_i,
    .rst_ni,
    .instr_valid_i,
    .instr_ready_o,
    .instr_i,
    .rs1_addr_o   (rs1_addr),
    .rs2_addr_o   (rs2_addr),
    .rs1_data_i   (rs1_data),
    .rs2_data_i   (rs2_data),
    .ex1_fwd_i    (ex1_fwd),
    .ex2_fwd_i    (ex2_fwd),
    .can_accept_i (can_accept),
    .candidate_o  (candidate),
    .issue_o      (issue_req)
  );

  // Writeback comes straight from the EX2 commit
  int_reg_file u_regfile (
    .clk_i,
    .rst_ni,
    .raddr_a_i (rs1_addr),
    .raddr_b_i (rs2_addr),
    .rdata_a_o (rs1_data),
    .rdata_b_o (rs2_data),
    .we_i      (commit_valid_o),
    .waddr_i   (commit_o.rd),
    .wdata_i   (commit_o.data)
  );

  exec_pipeline u_exec (
    .clk_i,
    .rst_ni,
    .candidate_i    (candidate),
    .issue_i        (issue_req),
    .can_accept_o   (can_accept),
    .ex1_fwd_o      (ex1_fwd),
    .ex2_fwd_o      (ex2_fwd),
    .commit_valid_o,
    .commit_o
  );

endmodule

// ==== src/int_reg_file.sv ====
`timescale 1ns/100ps

module int_reg_file import backend_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic [REG_ADDR_W-1:0] raddr_a_i,
  input  logic [REG_ADDR_W-1:0] raddr_b_i,
  output logic [XLEN-1:0]       rdata_a_o,
  output logic [XLEN-1:0]       rdata_b_o,
  input  logic                  we_i,
  input  logic [REG_ADDR_W-1:0] waddr_i,
  input  logic [XLEN-1:0]       wdata_i
);

  // Register 0 has no storage
  logic [XLEN-1:0] regs_q [NUM_REGS-1:1];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // Combinational reads, x0 reads as zero
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

// ==== src/issue_stage.sv ====
`timescale 1ns/100ps

module issue_stage import backend_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  instr_valid_i,
  output logic                  instr_ready_o,
  input  instr_t                instr_i,
  output logic [REG_ADDR_W-1:0] rs1_addr_o,
  output logic [REG_ADDR_W-1:0] rs2_addr_o,
  input  logic [XLEN-1:0]       rs1_data_i,
  input  logic [XLEN-1:0]       rs2_data_i,
  input  fwd_t                  ex1_fwd_i,
  input  fwd_t                  ex2_fwd_i,
  input  logic                  can_accept_i,
  output issue_t                candidate_o,
  output issue_t                issue_o
);

  logic            occupied_q;
  instr_t          instr_q;
  logic            accept;
  logic            use_rs2;
  logic [XLEN:0]   byp_a;
  logic [XLEN:0]   byp_b;
  logic            data_hazard;

  // Returns {hazard, data}, the younger EX1 result wins over EX2
  function automatic logic [XLEN:0] bypass_operand(
    input logic [REG_ADDR_W-1:0] rs,
    input logic [XLEN-1:0]       rf_data,
    input fwd_t                  ex1,
    input fwd_t                  ex2
  );
    logic            hazard;
    logic [XLEN-1:0] data;
    hazard = 1'b0;
    data   = rf_data;
    if (ex1.pending && ex1.rd == rs && rs != '0) begin
      hazard = !ex1.data_valid;
      data   = ex1.data;
    end else if (ex2.pending && ex2.rd == rs && rs != '0) begin
      hazard = !ex2.data_valid;
      data   = ex2.data;
    end
    return {hazard, data};
  endfunction

  ////////////////////
  // Issue register
  ////////////////////

  assign instr_ready_o = !occupied_q || issue_o.valid;
  assign accept        = instr_valid_i && instr_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      occupied_q <= 1'b0;
    end else if (accept) begin
      occupied_q <= 1'b1;
    end else if (issue_o.valid) begin
      occupied_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      instr_q <= instr_i;
    end
  end

  ////////////////////
  // Operand bypass
  ////////////////////

  assign rs1_addr_o = instr_q.rs1;
  assign rs2_addr_o = instr_q.rs2;

  // ADDI takes the immediate, so rs2 is not a dependency
  assign use_rs2     = instr_q.opcode != OPC_ADDI;
  assign byp_a       = bypass_operand(instr_q.rs1, rs1_data_i, ex1_fwd_i, ex2_fwd_i);
  assign byp_b       = bypass_operand(instr_q.rs2, rs2_data_i, ex1_fwd_i, ex2_fwd_i);
  assign data_hazard = byp_a[XLEN] || (use_rs2 && byp_b[XLEN]);

  always_comb begin
    candidate_o.valid  = occupied_q;
    candidate_o.opcode = instr_q.opcode;
    candidate_o.rd     = instr_q.rd;
    candidate_o.op_a   = byp_a[XLEN-1:0];
    candidate_o.op_b   = byp_b[XLEN-1:0];
    candidate_o.imm    = instr_q.imm;
  end

  always_comb begin
    issue_o       = candidate_o;
    issue_o.valid = occupied_q && !data_hazard && can_accept_i;
  end

  // An issued rs1 never depends on an EX slot still waiting on its unit
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_o.valid && instr_q.rs1 != '0 && ex1_fwd_i.pending && ex1_fwd_i.rd == instr_q.rs1
      |-> ex1_fwd_i.data_valid)
    else $error("ERR issue_o.valid with data hazard on rs1 %h", instr_q.rs1);

  // A stalled instruction stays in the issue register unchanged
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    occupied_q && !issue_o.valid |=> occupied_q && $stable(instr_q))
    else $error("ERR instr_q lost while stalled in issue register");

endmodule

// ==== src/iter_divider.sv ====
`timescale 1ns/100ps

module iter_divider import backend_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            req_valid_i,
  output logic            req_ready_o,
  input  logic            rem_i,
  input  logic [XLEN-1:0] op_a_i,
  input  logic [XLEN-1:0] op_b_i,
  output logic            resp_valid_o,
  output logic [XLEN-1:0] resp_value_o
);

  muldiv_state_e           state_q;
  logic [MULDIV_CNT_W-1:0] count_q;
  logic                    rem_sel_q;
  logic [XLEN-1:0]         divisor_q;
  logic [XLEN-1:0]         quo_q;
  logic [XLEN-1:0]         rem_q;
  logic [XLEN:0]           shifted;
  logic [XLEN:0]           trial;
  logic                    req_fire;

  assign req_ready_o  = state_q != MD_BUSY;
  assign req_fire     = req_valid_i && req_ready_o;
  assign resp_valid_o = state_q == MD_DONE;
  assign resp_value_o = rem_sel_q ? rem_q : quo_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= MD_IDLE;
      count_q <= '0;
    end else if (req_fire) begin
      state_q <= MD_BUSY;
      count_q <= MULDIV_CNT_W'(MULDIV_STEPS);
    end else if (state_q == MD_BUSY) begin
      count_q <= count_q - MULDIV_CNT_W'(1);
      if (count_q == MULDIV_CNT_W'(1)) begin
        state_q <= MD_DONE;
      end
    end
  end

  ////////////////////
  // Restoring step
  ////////////////////

  // Quotient register starts as the dividend and shifts its bits into the remainder
  assign shifted = {rem_q, quo_q[XLEN-1]};
  assign trial   = shifted - {1'b0, divisor_q};

  // A zero divisor never borrows, giving all ones and the dividend back
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      rem_sel_q <= rem_i;
      divisor_q <= op_b_i;
      quo_q     <= op_a_i;
      rem_q     <= '0;
    end else if (state_q == MD_BUSY) begin
      if (trial[XLEN]) begin
        rem_q <= shifted[XLEN-1:0];
        quo_q <= {quo_q[XLEN-2:0], 1'b0};
      end else begin
        rem_q <= trial[XLEN-1:0];
        quo_q <= {quo_q[XLEN-2:0], 1'b1};
      end
    end
  end

endmodule

// ==== src/iter_multiplier.sv ====
`timescale 1ns/100ps

module iter_multiplier import backend_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            req_valid_i,
  output logic            req_ready_o,
  input  logic [XLEN-1:0] op_a_i,
  input  logic [XLEN-1:0] op_b_i,
  output logic            resp_valid_o,
  output logic [XLEN-1:0] resp_value_o
);

  muldiv_state_e           state_q;
  logic [MULDIV_CNT_W-1:0] count_q;
  logic [XLEN-1:0]         mcand_q;
  logic [XLEN-1:0]         mplier_q;
  logic [XLEN-1:0]         acc_q;
  logic                    req_fire;

  assign req_ready_o  = state_q != MD_BUSY;
  assign req_fire     = req_valid_i && req_ready_o;
  assign resp_valid_o = state_q == MD_DONE;
  assign resp_value_o = acc_q;

  // Response is held in DONE until the next request
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= MD_IDLE;
      count_q <= '0;
    end else if (req_fire) begin
      state_q <= MD_BUSY;
      count_q <= MULDIV_CNT_W'(MULDIV_STEPS);
    end else if (state_q == MD_BUSY) begin
      count_q <= count_q - MULDIV_CNT_W'(1);
      if (count_q == MULDIV_CNT_W'(1)) begin
        state_q <= MD_DONE;
      end
    end
  end

  // Shift-add, bits above XLEN are dropped
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      mcand_q  <= op_a_i;
      mplier_q <= op_b_i;
      acc_q    <= '0;
    end else if (state_q == MD_BUSY) begin
      if (mplier_q[0]) begin
        acc_q <= acc_q + mcand_q;
      end
      mcand_q  <= mcand_q << 1;
      mplier_q <= mplier_q >> 1;
    end
  end

  // The structure check upstream keeps requests off a busy unit
  assert property (@(posedge clk_i) disable iff (!rst_ni) state_q == MD_BUSY |-> !req_valid_i)
    else $error("ERR req_valid_i while multiplier busy, op_a %h", op_a_i);

endmodule

// ==== testbench/tb_int_backend.sv ====
`timescale 1ns/100ps

module tb_int_backend import backend_pkg::*; ();

  localparam int          CLK_PERIOD   = 10;
  localparam int          RESET_CYCLES = 16;
  localparam int          SEED_LEN     = 7;
  localparam int          CHAIN_LEN    = 40;
  localparam int          MULDIV_LEN   = 24;
  localparam int          RANDOM_LEN   = 300;
  localparam int          ZERO_LEN     = 8;
  localparam int          PROG_LEN     = SEED_LEN + CHAIN_LEN + MULDIV_LEN + RANDOM_LEN + ZERO_LEN;
  localparam int unsigned SEED         = 32'hc155_d8e0;

  logic            clk_i;
  logic            rst_ni;
  logic            instr_valid_i;
  logic            instr_ready_o;
  instr_t          instr_i;
  logic            commit_valid_o;
  commit_t         commit_o;

  logic [XLEN-1:0] ref_regs [NUM_REGS];
  commit_t         exp_q [$];
  commit_t         exp_head;
  logic            exp_empty;
  logic            started;
  int unsigned     errors = 0;
  int unsigned     checks;
  int unsigned     accepted;
  int unsigned     committed;
  int unsigned     total_errors;

  int_backend uut (
    .clk_i,
    .rst_ni,
    .instr_valid_i,
    .instr_ready_o,
    .instr_i,
    .commit_valid_o,
    .commit_o
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  ////////////////////
  // Reference model
  ////////////////////

  function automatic logic [XLEN-1:0] reference_result(input instr_t ins,
                                                       input logic [XLEN-1:0] a,
                                                       input logic [XLEN-1:0] b);
    logic [XLEN-1:0] imm_ext;
    imm_ext = XLEN'(signed'(ins.imm));
    case (ins.opcode)
      OPC_ADD:  return a + b;
      OPC_SUB:  return a - b;
      OPC_AND:  return a & b;
      OPC_OR:   return a | b;
      OPC_XOR:  return a ^ b;
      OPC_SLL:  return a << b[4:0];
      OPC_SRL:  return a >> b[4:0];
      OPC_ADDI: return a + imm_ext;
      OPC_MUL:  return a * b;
      // Division by zero gives all ones, remainder by zero the dividend
      OPC_DIVU: return (b == '0) ? '1 : a / b;
      OPC_REMU: return (b == '0) ? a : a % b;
      default:  return '0;
    endcase
  endfunction

  // Older commit leaves the queue before the newly accepted instruction joins it
  always @(posedge clk_i) begin
    commit_t entry;
    if (!rst_ni) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        ref_regs[i] = '0;
      end
      exp_q.delete();
      checks    = 0;
      accepted  = 0;
      committed = 0;
      exp_head  <= '0;
      exp_empty <= 1'b1;
    end else begin
      if (commit_valid_o) begin
        checks++;
        committed++;
        if (exp_q.size() != 0) begin
          void'(exp_q.pop_front());
        end
      end
      if (instr_valid_i && instr_ready_o) begin
        entry.rd   = instr_i.rd;
        entry.data = reference_result(instr_i, ref_regs[instr_i.rs1], ref_regs[instr_i.rs2]);
        if (instr_i.rd != '0) begin
          ref_regs[instr_i.rd] = entry.data;
        end
        exp_q.push_back(entry);
        accepted++;
      end
      exp_empty <= exp_q.size() == 0;
      exp_head  <= (exp_q.size() != 0) ? exp_q[0] : '0;
    end
  end

  ////////////////////
  // Checks
  ////////////////////

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    !started |-> !commit_valid_o && instr_ready_o)
    else begin
      errors++;
      $display("ERR commit_valid_o/instr_ready_o exp 0/1 got %h/%h",
               $sampled(commit_valid_o), $sampled(instr_ready_o));
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni) commit_valid_o |-> !exp_empty)
    else begin
      errors++;
      $display("commit seen with no instruction outstanding, rd %h",
               $sampled(commit_o.rd));
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    commit_valid_o && !exp_empty |-> commit_o.rd == exp_head.rd)
    else begin
      errors++;
      $display("ERR commit_o.rd exp %h got %h", $sampled(exp_head.rd), $sampled(commit_o.rd));
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    commit_valid_o && !exp_empty |-> commit_o.data == exp_head.data)
    else begin
      errors++;
      $display("ERR commit_o.data exp %h got %h (rd %h)", $sampled(exp_head.data),
               $sampled(commit_o.data), $sampled(exp_head.rd));
    end

  ////////////////////
  // Stimulus
  ////////////////////

  function automatic instr_t make_instr(input opcode_e op, input int unsigned rd,
                                        input int unsigned rs1, input int unsigned rs2,
                                        input int unsigned imm);
    instr_t ins;
    ins.opcode = op;
    ins.rd     = REG_ADDR_W'(rd);
    ins.rs1    = REG_ADDR_W'(rs1);
    ins.rs2    = REG_ADDR_W'(rs2);
    ins.imm    = IMM_W'(imm);
    return ins;
  endfunction

  // Small register window keeps dependencies frequent
  function automatic instr_t random_instr();
    opcode_e op;
    op = opcode_e'(4'($urandom_range(10, 0)));
    return make_instr(op, $urandom_range(7, 0), $urandom_range(7, 0),
                      $urandom_range(7, 0), $urandom);
  endfunction

  // Called on a falling edge, returns on the falling edge after the transfer
  task automatic send_instr(input instr_t ins, input int unsigned gap);
    if (gap != 0) begin
      instr_valid_i = 1'b0;
      repeat (gap) @(negedge clk_i);
    end
    instr_valid_i = 1'b1;
    instr_i       = ins;
    started       = 1'b1;
    while (!instr_ready_o) begin
      @(negedge clk_i);
    end
    @(negedge clk_i);
  endtask

  initial begin
    int unsigned gap;
    void'($urandom(SEED));
    rst_ni        = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    started       = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk_i);
    rst_ni = 1'b1;
    repeat (4) @(negedge clk_i);

    // Give the working registers nonzero values
    for (int r = 1; r <= SEED_LEN; r++) begin
      send_instr(make_instr(OPC_ADDI, r, 0, 0, $urandom), 0);
    end

    // Each source is the result of one or two instructions back
    for (int i = 0; i < CHAIN_LEN; i++) begin
      send_instr(make_instr(opcode_e'(4'($urandom_range(7, 0))), 1 + i % 7,
                            1 + (i + 6) % 7, 1 + (i + 5) % 7, $urandom), 0);
    end

    // Same-unit pairs, each depending on the one before, with x0 divisors
    for (int k = 0; k < MULDIV_LEN / 4; k++) begin
      send_instr(make_instr(OPC_MUL, 1, $urandom_range(7, 1), $urandom_range(7, 1), 0), 0);
      send_instr(make_instr(OPC_MUL, 2, 1, $urandom_range(7, 1), 0), 0);
      send_instr(make_instr(OPC_DIVU, 3, 2, (k % 3 == 0) ? 0 : 1, 0), 0);
      send_instr(make_instr(OPC_REMU, 4, 3, (k % 3 == 1) ? 0 : 2, 0), 0);
    end

    for (int i = 0; i < RANDOM_LEN; i++) begin
      gap = ($urandom_range(3, 0) == 0) ? $urandom_range(3, 1) : 0;
      send_instr(random_instr(), gap);
    end

    // Write x0, then read it straight back
    for (int j = 0; j < ZERO_LEN / 2; j++) begin
      send_instr(make_instr(OPC_ADDI, 0, 1 + j, 0, $urandom), 0);
      send_instr(make_instr(OPC_ADD, 5 + j % 3, 0, 1 + j, 0), 0);
    end

    instr_valid_i = 1'b0;
    while (exp_q.size() != 0) begin
      @(negedge clk_i);
    end
    // Room for a duplicated commit to show up
    repeat (MULDIV_STEPS + 10) @(negedge clk_i);

    total_errors = errors;
    if (committed != accepted) begin
      total_errors++;
      $display("%0d commits seen for %0d accepted instructions", committed, accepted);
    end
    $display("checks %0d, errors %0d", checks, total_errors);
    if (total_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  initial begin
    #((RESET_CYCLES + 20 + PROG_LEN * (MULDIV_STEPS + 10)) * CLK_PERIOD);
    $display("watchdog expired with %0d instructions outstanding", exp_q.size());
    $display("** FAIL **");
    $finish;
  end

endmodule
